/* design/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Data word and row packing.
`define MEM_WIDTH    32
`define MEM_NUMWRDS  4
`define MEM_BITWRDS  2

// Physical bank array.
`define MEM_NUMBANK  4
`define MEM_BITBANK  2
`define MEM_NUMSROW  64
`define MEM_BITSROW  6
`define MEM_BITADDR  10  // Bank, then sub-row, then lane.

`define MEM_DELAY    2   // Edges from read sampling to valid row data.

// Refresh timing per bank.
`define MEM_REFFREQ  16
`define MEM_NUMRBNK  4
`define MEM_BITRBNK  2

`endif

/* design/mem_addr_pkg.sv */
`include "mem_consts.svh"

package mem_addr_pkg;

  typedef logic [`MEM_BITADDR-1:0] addr_t;  // Flat word address.
  typedef logic [`MEM_BITBANK-1:0] bank_t;
  typedef logic [`MEM_BITSROW-1:0] srow_t;
  typedef logic [`MEM_BITWRDS-1:0] lane_t;
  typedef logic [`MEM_BITRBNK-1:0] rbank_t;

  // Per-bank vectors, bank 0 in the low bits.
  typedef logic [`MEM_NUMBANK-1:0]              bank_vec_t;
  typedef logic [`MEM_NUMBANK*`MEM_BITSROW-1:0] srow_vec_t;
  typedef logic [`MEM_NUMBANK*`MEM_BITRBNK-1:0] rbank_vec_t;

endpackage

/* design/mem_data_pkg.sv */
`include "mem_consts.svh"

package mem_data_pkg;

  typedef logic [`MEM_WIDTH-1:0] word_t;

  // A physical row holds MEM_NUMWRDS words, lane 0 in the low bits.
  typedef logic [`MEM_NUMWRDS*`MEM_WIDTH-1:0] row_t;
  typedef logic [`MEM_NUMWRDS-1:0]            lane_mask_t;

  typedef logic [`MEM_NUMBANK*`MEM_NUMWRDS*`MEM_WIDTH-1:0] row_vec_t;

endpackage

/* design/access_decode.sv */
`timescale 1ns/1ns
`include "mem_consts.svh"

module access_decode (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                read,
  input  logic                write,
  input  mem_addr_pkg::addr_t addr,
  input  mem_data_pkg::word_t din,
  output logic                ready,
  output logic                dec_read,
  output logic                dec_write,
  output mem_addr_pkg::bank_t dec_bank,
  output mem_addr_pkg::srow_t dec_srow,
  output mem_addr_pkg::lane_t dec_lane,
  output mem_data_pkg::word_t dec_din,
  output logic                dec_clear
);

  import mem_addr_pkg::*;

  typedef enum logic {ST_CLEAR, ST_RUN} state_t;

  state_t state;
  srow_t  sweep_cnt;
  logic   accept;

  assign accept = ready & (read | write);  // Requests before ready are dropped.

  //////////////////////////////////////////////////
  // Clear sweep and request strobes
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= ST_CLEAR;
      sweep_cnt <= '0;
      dec_clear <= 1'b0;
      ready     <= 1'b0;
      dec_read  <= 1'b0;
      dec_write <= 1'b0;
    end else begin
      dec_read  <= read & ready;
      dec_write <= write & ready;
      case (state)
        ST_CLEAR: begin
          dec_clear <= 1'b1;                 // One row of every bank per cycle.
          sweep_cnt <= sweep_cnt + 1'b1;
          if (sweep_cnt == srow_t'(`MEM_NUMSROW - 1)) begin
            state <= ST_RUN;
          end
        end
        default: begin
          dec_clear <= 1'b0;
          ready     <= 1'b1;
        end
      endcase
    end
  end

  // Address fields, bank on top and lane at the bottom.
  always_ff @(posedge clk) begin
    if (state == ST_CLEAR) begin
      dec_srow <= sweep_cnt;
    end else if (accept) begin
      dec_bank <= addr[`MEM_BITADDR-1 -: `MEM_BITBANK];
      dec_srow <= addr[`MEM_BITWRDS +: `MEM_BITSROW];
      dec_lane <= addr[`MEM_BITWRDS-1:0];
      dec_din  <= din;
    end
  end

endmodule

/* design/row_align.sv */
`timescale 1ns/1ns
`include "mem_consts.svh"

module row_align (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      dec_read,
  input  logic                      dec_write,
  input  mem_addr_pkg::bank_t       dec_bank,
  input  mem_addr_pkg::srow_t       dec_srow,
  input  mem_addr_pkg::lane_t       dec_lane,
  input  mem_data_pkg::word_t       dec_din,
  input  logic                      dec_clear,
  output mem_addr_pkg::bank_vec_t   mem_read,
  output mem_addr_pkg::bank_vec_t   mem_write,
  output mem_addr_pkg::srow_vec_t   mem_addr,
  output mem_data_pkg::row_vec_t    mem_bw,
  output mem_data_pkg::row_vec_t    mem_din,
  output mem_addr_pkg::bank_vec_t   busy_next,
  output logic                      rd_issue,
  output mem_addr_pkg::lane_t       rd_lane,
  output mem_addr_pkg::bank_t       rd_bank
);

  import mem_addr_pkg::*;
  import mem_data_pkg::*;

  bank_vec_t  bank_sel;
  lane_mask_t lane_mask;
  row_t       row_bw;
  row_t       row_din;

  always_comb begin
    bank_sel            = '0;
    bank_sel[dec_bank]  = 1'b1;
    lane_mask           = '0;
    lane_mask[dec_lane] = 1'b1;
    for (int i = 0; i < `MEM_NUMWRDS; i++) begin
      row_bw[i*`MEM_WIDTH +: `MEM_WIDTH]  = {`MEM_WIDTH{lane_mask[i] | dec_clear}};
      row_din[i*`MEM_WIDTH +: `MEM_WIDTH] = dec_clear ? '0 : dec_din;  // Word in every lane.
    end
  end

  // Banks that carry a command in the next registered cycle.
  assign busy_next = dec_clear ? '1 : ((dec_read | dec_write) ? bank_sel : '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_read  <= '0;
      mem_write <= '0;
      rd_issue  <= 1'b0;
    end else begin
      mem_read  <= dec_read ? bank_sel : '0;
      mem_write <= dec_clear ? '1 : (dec_write ? bank_sel : '0);
      rd_issue  <= dec_read;
    end
  end

  always_ff @(posedge clk) begin
    mem_addr <= {`MEM_NUMBANK{dec_srow}};  // Only the strobed bank uses it.
    mem_bw   <= {`MEM_NUMBANK{row_bw}};
    mem_din  <= {`MEM_NUMBANK{row_din}};
    rd_lane  <= dec_lane;
    rd_bank  <= dec_bank;
  end

endmodule

/* design/refresh_sched.sv */
`timescale 1ns/1ns
`include "mem_consts.svh"

module refresh_sched (
  input  logic                     clk,
  input  logic                     rst_n,
  input  mem_addr_pkg::bank_vec_t  busy_next,
  output mem_addr_pkg::bank_vec_t  mem_refr,
  output mem_addr_pkg::rbank_vec_t mem_refr_bank
);

  import mem_addr_pkg::*;

  typedef logic [$clog2(`MEM_REFFREQ)-1:0] tick_t;

  tick_t     period_cnt [`MEM_NUMBANK];
  rbank_t    next_rbank [`MEM_NUMBANK];
  bank_vec_t pending;
  bank_vec_t tick_done;
  bank_vec_t issue;

  always_comb begin
    for (int b = 0; b < `MEM_NUMBANK; b++) begin
      tick_done[b] = (period_cnt[b] == tick_t'(`MEM_REFFREQ - 1));
      issue[b]     = pending[b] & ~busy_next[b];  // Access always wins the bank.
    end
  end

  //////////////////////////////////////////////////
  // Per-bank timers
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending       <= '0;
      mem_refr      <= '0;
      mem_refr_bank <= '0;
      for (int b = 0; b < `MEM_NUMBANK; b++) begin
        period_cnt[b] <= '0;
        next_rbank[b] <= '0;
      end
    end else begin
      for (int b = 0; b < `MEM_NUMBANK; b++) begin
        period_cnt[b] <= tick_done[b] ? '0 : period_cnt[b] + 1'b1;
        pending[b]    <= tick_done[b] | (pending[b] & ~issue[b]);  // A flag, so no stacking.
        mem_refr[b]   <= issue[b];
        if (issue[b]) begin
          mem_refr_bank[b*`MEM_BITRBNK +: `MEM_BITRBNK] <= next_rbank[b];
          if (next_rbank[b] == rbank_t'(`MEM_NUMRBNK - 1)) begin
            next_rbank[b] <= '0;
          end else begin
            next_rbank[b] <= next_rbank[b] + 1'b1;
          end
        end
      end
    end
  end

endmodule

/* design/read_return.sv */
`timescale 1ns/1ns
`include "mem_consts.svh"

module read_return (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rd_issue,
  input  mem_addr_pkg::lane_t    rd_lane,
  input  mem_addr_pkg::bank_t    rd_bank,
  input  mem_data_pkg::row_vec_t mem_dout,
  output logic                   rd_vld,
  output mem_data_pkg::word_t    rd_dout
);

  import mem_addr_pkg::*;
  import mem_data_pkg::*;

  // Stage 0 lines up with the edge where the memory samples the read.
  logic [`MEM_DELAY:0] tag_vld;
  bank_t               tag_bank [`MEM_DELAY+1];
  lane_t               tag_lane [`MEM_DELAY+1];
  row_t                sel_row;
  word_t               sel_word;

  assign sel_row  = mem_dout[tag_bank[`MEM_DELAY]*$bits(row_t) +: $bits(row_t)];
  assign sel_word = sel_row[tag_lane[`MEM_DELAY]*$bits(word_t) +: $bits(word_t)];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tag_vld <= '0;
      rd_vld  <= 1'b0;
    end else begin
      tag_vld <= {tag_vld[`MEM_DELAY-1:0], rd_issue};
      rd_vld  <= tag_vld[`MEM_DELAY];
    end
  end

  always_ff @(posedge clk) begin
    tag_bank[0] <= rd_bank;
    tag_lane[0] <= rd_lane;
    for (int i = 1; i <= `MEM_DELAY; i++) begin
      tag_bank[i] <= tag_bank[i-1];
      tag_lane[i] <= tag_lane[i-1];
    end
    if (tag_vld[`MEM_DELAY]) begin
      rd_dout <= sel_word;  // Row data is valid only in this cycle.
    end
  end

endmodule

/* design/banked_mem_top.sv */
`timescale 1ns/1ns

module banked_mem_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     read,
  input  logic                     write,
  input  mem_addr_pkg::addr_t      addr,
  input  mem_data_pkg::word_t      din,
  output logic                     ready,
  output logic                     rd_vld,
  output mem_data_pkg::word_t      rd_dout,
  output mem_addr_pkg::bank_vec_t  mem_read,
  output mem_addr_pkg::bank_vec_t  mem_write,
  output mem_addr_pkg::srow_vec_t  mem_addr,
  output mem_data_pkg::row_vec_t   mem_bw,
  output mem_data_pkg::row_vec_t   mem_din,
  input  mem_data_pkg::row_vec_t   mem_dout,
  output mem_addr_pkg::bank_vec_t  mem_refr,
  output mem_addr_pkg::rbank_vec_t mem_refr_bank
);

  import mem_addr_pkg::*;
  import mem_data_pkg::*;

  logic      dec_read;
  logic      dec_write;
  logic      dec_clear;
  bank_t     dec_bank;
  srow_t     dec_srow;
  lane_t     dec_lane;
  word_t     dec_din;
  bank_vec_t busy_next;
  logic      rd_issue;
  lane_t     rd_lane;
  bank_t     rd_bank;

  access_decode u_decode (
    .clk(clk), .rst_n(rst_n), .read(read), .write(write), .addr(addr), .din(din),
    .ready(ready), .dec_read(dec_read), .dec_write(dec_write), .dec_bank(dec_bank),
    .dec_srow(dec_srow), .dec_lane(dec_lane), .dec_din(dec_din), .dec_clear(dec_clear)
  );

  row_align u_align (
    .clk(clk), .rst_n(rst_n), .dec_read(dec_read), .dec_write(dec_write),
    .dec_bank(dec_bank), .dec_srow(dec_srow), .dec_lane(dec_lane), .dec_din(dec_din),
    .dec_clear(dec_clear), .mem_read(mem_read), .mem_write(mem_write),
    .mem_addr(mem_addr), .mem_bw(mem_bw), .mem_din(mem_din), .busy_next(busy_next),
    .rd_issue(rd_issue), .rd_lane(rd_lane), .rd_bank(rd_bank)
  );

  refresh_sched u_refresh (  // Runs beside the align stage.
    .clk(clk), .rst_n(rst_n), .busy_next(busy_next),
    .mem_refr(mem_refr), .mem_refr_bank(mem_refr_bank)
  );

  read_return u_return (
    .clk(clk), .rst_n(rst_n), .rd_issue(rd_issue), .rd_lane(rd_lane),
    .rd_bank(rd_bank), .mem_dout(mem_dout), .rd_vld(rd_vld), .rd_dout(rd_dout)
  );

endmodule

/* verification/tb_mem_model.sv */
`timescale 1ns/1ns
`include "mem_consts.svh"

module tb_mem_model (
  input  logic                    clk,
  input  mem_addr_pkg::bank_vec_t mem_read,
  input  mem_addr_pkg::bank_vec_t mem_write,
  input  mem_addr_pkg::srow_vec_t mem_addr,
  input  mem_data_pkg::row_vec_t  mem_bw,
  input  mem_data_pkg::row_vec_t  mem_din,
  output mem_data_pkg::row_vec_t  mem_dout
);

  import mem_addr_pkg::*;
  import mem_data_pkg::*;

  localparam int ROW_W = $bits(row_t);

  row_t     mem [`MEM_NUMBANK][`MEM_NUMSROW];
  row_vec_t rd_pipe [`MEM_DELAY+1];  // Stage 0 loads at the edge that samples the read.
  int       seed;

  assign mem_dout = rd_pipe[`MEM_DELAY];

  // Random start contents, so only the clear sweep can make them zero.
  initial begin
    seed = 32'h814c;
    for (int b = 0; b < `MEM_NUMBANK; b++) begin
      for (int r = 0; r < `MEM_NUMSROW; r++) begin
        mem[b][r] <= {$random(seed), $random(seed), $random(seed), $random(seed)};
      end
    end
  end

  always @(posedge clk) begin
    for (int b = 0; b < `MEM_NUMBANK; b++) begin
      if (mem_write[b]) begin
        mem[b][mem_addr[b*`MEM_BITSROW +: `MEM_BITSROW]] <=
          (mem[b][mem_addr[b*`MEM_BITSROW +: `MEM_BITSROW]] & ~mem_bw[b*ROW_W +: ROW_W]) |
          (mem_din[b*ROW_W +: ROW_W] & mem_bw[b*ROW_W +: ROW_W]);  // Bit-write mask.
      end
      if (mem_read[b]) begin
        rd_pipe[0][b*ROW_W +: ROW_W] <= mem[b][mem_addr[b*`MEM_BITSROW +: `MEM_BITSROW]];
      end
    end
    for (int i = 1; i <= `MEM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

endmodule

/* verification/tb_banked_mem.sv */
`timescale 1ns/1ns
`include "mem_consts.svh"

module tb_banked_mem;

  import mem_addr_pkg::*;
  import mem_data_pkg::*;

  localparam int ROW_W       = $bits(row_t);
  localparam int RD_LATENCY  = `MEM_DELAY + 3;  // Sampling edge to rd_vld.
  localparam int CYCLE_LIMIT = 4000;            // Sweep, all tests and a wide margin.
  localparam int HOT_BANK    = 1;

  logic       clk;
  logic       rst_n;
  logic       read;
  logic       write;
  addr_t      addr;
  word_t      din;
  logic       ready;
  logic       rd_vld;
  word_t      rd_dout;
  bank_vec_t  mem_read;
  bank_vec_t  mem_write;
  srow_vec_t  mem_addr;
  row_vec_t   mem_bw;
  row_vec_t   mem_din;
  row_vec_t   mem_dout;
  bank_vec_t  mem_refr;
  rbank_vec_t mem_refr_bank;

  word_t shadow [2**`MEM_BITADDR];  // Expected contents, all zero after the sweep.
  word_t exp_data [$];
  int    exp_cycle [$];
  int    refr_cnt [`MEM_NUMBANK] = '{default: 0};
  int    cycle = 0;
  int    seed;
  int    value_errors;
  int    other_errors;
  string test_name;

  banked_mem_top DUT (.*);
  tb_mem_model u_mem (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  initial begin
    wait (cycle >= CYCLE_LIMIT);
    $display("Timeout after %0d cycles", cycle);
    $display("Some tests failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_row(input string name, input row_t expected, input row_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_rbank(input string name, input rbank_t expected, input rbank_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_bank_vec(input string name, input bank_vec_t expected,
                                input bank_vec_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_srow(input string name, input srow_t expected, input srow_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
      value_errors++;
    end
  endtask

  // Read returns in order and refresh rules, sampled mid-cycle.
  always @(negedge clk) begin
    if (rst_n) begin
      if (rd_vld && exp_cycle.size() == 0) begin
        $display("rd_vld rose at cycle %0d with no read in flight", cycle);
        other_errors++;
      end else if (rd_vld) begin
        if (exp_cycle[0] != cycle) begin
          $display("Read returned at cycle %0d, due at cycle %0d", cycle, exp_cycle[0]);
          other_errors++;
        end
        check_word(test_name, exp_data.pop_front(), rd_dout);
        void'(exp_cycle.pop_front());
      end else if (exp_cycle.size() != 0 && exp_cycle[0] <= cycle) begin
        $display("No rd_vld for the read due at cycle %0d", exp_cycle[0]);
        other_errors++;
        void'(exp_data.pop_front());
        void'(exp_cycle.pop_front());
      end
      for (int b = 0; b < `MEM_NUMBANK; b++) begin
        if (mem_refr[b]) begin
          if (mem_read[b] | mem_write[b]) begin
            $display("Bank %0d refreshed during an access at cycle %0d", b, cycle);
            other_errors++;
          end
          check_rbank(test_name, rbank_t'(refr_cnt[b] % `MEM_NUMRBNK),
                      mem_refr_bank[b*`MEM_BITRBNK +: `MEM_BITRBNK]);
          refr_cnt[b]++;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Port drivers
  //////////////////////////////////////////////////
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic do_write(input addr_t a, input word_t d);
    write     = 1'b1;
    addr      = a;
    din       = d;
    shadow[a] = d;
    step();
    write = 1'b0;
  endtask

  task automatic do_read(input addr_t a);
    read = 1'b1;
    addr = a;
    exp_data.push_back(shadow[a]);
    exp_cycle.push_back(cycle + 1 + RD_LATENCY);
    step();
    read = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_cycle.size() != 0 && n < 2 * RD_LATENCY) begin
      step();
      n++;
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic test_clear();
    int n;
    test_name = "clear";
    n = 0;
    while (!ready && n < 2 * `MEM_NUMSROW) begin
      step();
      n++;
    end
    if (!ready) begin
      $display("ready did not rise after the clear sweep");
      other_errors++;
    end
    repeat (32) do_read(addr_t'($random(seed)));
    drain();
  endtask

  task automatic test_write_read();
    addr_t wr_addr [256];
    addr_t row_base;
    test_name = "write_read";
    foreach (wr_addr[i]) begin
      wr_addr[i] = addr_t'($random(seed));
      do_write(wr_addr[i], word_t'($random(seed)));
    end
    foreach (wr_addr[i]) do_read(wr_addr[i]);
    drain();
    row_base = addr_t'($random(seed)) & ~addr_t'(`MEM_NUMWRDS - 1);
    for (int l = 0; l < `MEM_NUMWRDS; l++) begin
      do_write(row_base | addr_t'(l), word_t'($random(seed)));
    end
    do_write(row_base | addr_t'(2), word_t'($random(seed)));  // Lanes 0, 1, 3 must hold.
    for (int l = 0; l < `MEM_NUMWRDS; l++) begin
      do_read(row_base | addr_t'(l));
    end
    drain();
  endtask

  task automatic test_write_port();
    addr_t     a;
    word_t     d;
    bank_t     bank;
    lane_t     lane;
    bank_vec_t exp_vec;
    row_t      exp_bw;
    test_name = "write_port";
    repeat (16) begin
      a             = addr_t'($random(seed));
      d             = word_t'($random(seed));
      bank          = a[`MEM_BITADDR-1 -: `MEM_BITBANK];
      lane          = a[`MEM_BITWRDS-1:0];
      exp_vec       = '0;
      exp_vec[bank] = 1'b1;
      for (int l = 0; l < `MEM_NUMWRDS; l++) begin
        exp_bw[l*`MEM_WIDTH +: `MEM_WIDTH] = {`MEM_WIDTH{l == int'(lane)}};
      end
      do_write(a, d);
      step();  // Command leaves the align stage one edge after decode.
      check_bank_vec(test_name, exp_vec, mem_write);
      check_srow(test_name, a[`MEM_BITWRDS +: `MEM_BITSROW],
                 mem_addr[bank*`MEM_BITSROW +: `MEM_BITSROW]);
      check_row(test_name, exp_bw, mem_bw[bank*ROW_W +: ROW_W]);
      check_row(test_name, {`MEM_NUMWRDS{d}}, mem_din[bank*ROW_W +: ROW_W]);
    end
  endtask

  task automatic test_back_to_back();
    test_name = "back_to_back";
    repeat (64) do_read(addr_t'($random(seed)));
    drain();
  endtask

  task automatic test_refresh();
    int    last [`MEM_NUMBANK];
    int    pulses [`MEM_NUMBANK];
    int    n;
    logic  seen;
    addr_t a;
    test_name = "refresh";
    repeat (2 * `MEM_REFFREQ) step();  // Refreshes held back by earlier traffic settle.
    foreach (pulses[b]) begin
      pulses[b] = 0;
      last[b]   = 0;
    end
    repeat (5 * `MEM_REFFREQ) begin
      for (int b = 0; b < `MEM_NUMBANK; b++) begin
        if (mem_refr[b] && pulses[b] != 0 && cycle - last[b] != `MEM_REFFREQ) begin
          $display("Bank %0d refresh came %0d cycles after the last one", b, cycle - last[b]);
          other_errors++;
        end
        if (mem_refr[b]) begin
          last[b] = cycle;
          pulses[b]++;
        end
      end
      step();
    end
    foreach (pulses[b]) begin
      if (pulses[b] != 5) begin
        $display("Bank %0d refreshed %0d times in five idle periods", b, pulses[b]);
        other_errors++;
      end
    end
    repeat (3 * `MEM_REFFREQ) begin
      a = addr_t'($random(seed));
      a[`MEM_BITADDR-1 -: `MEM_BITBANK] = bank_t'(HOT_BANK);
      do_write(a, word_t'($random(seed)));
    end
    n = 0;
    while (mem_write[HOT_BANK] && n < RD_LATENCY) begin
      step();
      n++;
    end
    seen = mem_refr[HOT_BANK];
    step();
    seen = seen | mem_refr[HOT_BANK];
    if (!seen) begin
      $display("Bank %0d did not refresh within one cycle after its traffic stopped", HOT_BANK);
      other_errors++;
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    read         = 1'b0;
    write        = 1'b0;
    addr         = '0;
    din          = '0;
    seed         = 32'h814c;
    value_errors = 0;
    other_errors = 0;
    test_name    = "reset";
    foreach (shadow[i]) shadow[i] = '0;
    repeat (5) step();
    rst_n = 1'b1;
    test_clear();
    test_write_read();
    test_write_port();
    test_back_to_back();
    test_refresh();
    drain();
    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+design
design/mem_addr_pkg.sv
design/mem_data_pkg.sv
design/access_decode.sv
design/row_align.sv
design/refresh_sched.sv
design/read_return.sv
design/banked_mem_top.sv
verification/tb_mem_model.sv
verification/tb_banked_mem.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -j 0 \
  --top-module tb_banked_mem -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_banked_mem)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "All tests passed"; then
  exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
